// ==== dv/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    import cpuBusPkg::*;

    localparam int IMEM_DEPTH     = 64;
    localparam int NUM_ROWS       = 20;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 40 + NUM_ROWS + 10;  // Run, load and reset

    typedef struct packed {
        logic [31:0] instr;
        logic [4:0]  rd;
        logic [31:0] result;
        logic        legal;
        logic [2:0]  group;
    } row_t;

    logic       CLK;
    logic       RST;
    logic       run;
    logic       progValid;
    logic       progReady;
    progWrite_t progData;
    logic       retireValid;
    logic       retireReady;
    retire_t    retireData;
    logic       checkDone;
    int         errCount;
    int         seed;
    int         rowCount;
    row_t       rows [NUM_ROWS];

    cpuTop #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) DUT (
        .CLK         (CLK),
        .RST         (RST),
        .run         (run),
        .progValid   (progValid),
        .progReady   (progReady),
        .progData    (progData),
        .retireValid (retireValid),
        .retireReady (retireReady),
        .retireData  (retireData)
    );

    retireChecker #(
        .NUM_ROWS (NUM_ROWS)
    ) uChecker (
        .CLK         (CLK),
        .RST         (RST),
        .run         (run),
        .progReady   (progReady),
        .retireValid (retireValid),
        .retireReady (retireReady),
        .retireData  (retireData),
        .done        (checkDone),
        .errCount    (errCount)
    );

    initial CLK = 1'b0;
    always #4 CLK = ~CLK;                       // 8 ns period

    function automatic logic [31:0] rTypeWord(input logic [6:0] funct7, input int rs2,
                                              input int rs1, input int funct3, input int rd);
        return {funct7, 5'(rs2), 5'(rs1), 3'(funct3), 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input int rs1,
                                              input int funct3, input int rd);
        return {imm, 5'(rs1), 3'(funct3), 5'(rd), 7'b0010011};
    endfunction

    task automatic addRow(input logic [31:0] word, input int rd, input logic [31:0] result,
                          input int legal, input int group);
        rows[rowCount] = '{word, 5'(rd), result, 1'(legal), 3'(group)};
        rowCount++;
    endtask

    // Expected results worked out by hand
    task automatic fillTable();
        rowCount = 0;
        addRow(iTypeWord(12'h005, 0, 0, 1), 1, 32'h00000005, 1, 1);     // ADDI x1, x0, 5
        addRow(iTypeWord(12'hFFD, 0, 0, 2), 2, 32'hFFFFFFFD, 1, 1);     // ADDI x2, x0, -3
        addRow(iTypeWord(12'h7FF, 0, 0, 3), 3, 32'h000007FF, 1, 1);     // ADDI x3, x0, 2047
        addRow(iTypeWord(12'h800, 0, 0, 4), 4, 32'hFFFFF800, 1, 1);     // ADDI x4, x0, -2048
        addRow(iTypeWord(12'hFF6, 1, 0, 5), 5, 32'hFFFFFFFB, 1, 1);     // ADDI x5, x1, -10
        addRow(rTypeWord(7'h00, 2, 1, 0, 6), 6, 32'h00000002, 1, 2);    // ADD x6, x1, x2
        addRow(rTypeWord(7'h20, 1, 0, 0, 7), 7, 32'hFFFFFFFB, 1, 2);    // SUB x7, x0, x1 wraps
        addRow(rTypeWord(7'h20, 1, 4, 5, 8), 8, 32'hFFFFFFC0, 1, 2);    // SRA x8, x4, x1
        addRow(rTypeWord(7'h00, 1, 4, 5, 9), 9, 32'h07FFFFC0, 1, 2);    // SRL x9, x4, x1
        addRow(rTypeWord(7'h00, 1, 2, 2, 10), 10, 32'h00000001, 1, 2);  // SLT x10, x2, x1
        addRow(rTypeWord(7'h00, 1, 2, 3, 11), 11, 32'h00000000, 1, 2);  // SLTU x11, x2, x1
        addRow(rTypeWord(7'h00, 3, 1, 1, 12), 12, 32'h80000000, 1, 2);  // SLL x12, x1, x3
        addRow(rTypeWord(7'h00, 2, 12, 4, 13), 13, 32'h7FFFFFFD, 1, 2); // XOR x13, x12, x2
        addRow(iTypeWord(12'h401, 2, 5, 14), 14, 32'hFFFFFFFE, 1, 2);   // SRAI x14, x2, 1
        addRow(iTypeWord(12'hFFC, 5, 2, 15), 15, 32'h00000001, 1, 2);   // SLTI x15, x5, -4
        addRow(iTypeWord(12'h007, 1, 0, 0), 0, 32'h0000000C, 1, 3);     // ADDI x0, x1, 7
        addRow(rTypeWord(7'h00, 3, 0, 0, 16), 16, 32'h000007FF, 1, 3);  // ADD x16, x0, x3
        addRow(32'h0000A283, 5, 32'h00000000, 0, 4);                    // LW x5, 0(x1)
        addRow(rTypeWord(7'h01, 3, 1, 0, 6), 6, 32'h00000000, 0, 4);    // funct7 0000001
        addRow(rTypeWord(7'h00, 6, 5, 0, 17), 17, 32'hFFFFFFFD, 1, 4);  // Old x5 plus old x6
    endtask

    // Retire back-pressure, high about two cycles in three
    initial begin
        retireReady = 1'b0;
        forever begin
            @(posedge CLK);
            #1;
            retireReady = ($unsigned($random(seed)) % 3) != 0;
        end
    end

    initial begin
        seed      = 32'he6d9;
        RST       = 1'b1;
        run       = 1'b0;
        progValid = 1'b0;
        progData  = '0;
        fillTable();
        for (int i = 0; i < NUM_ROWS; i++) begin
            uChecker.loadExpected(i, rows[i].instr, rows[i].rd, rows[i].result,
                                  rows[i].legal, !rows[i].legal, int'(rows[i].group));
        end
        repeat (3) @(posedge CLK);
        #1;
        RST = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            progValid     = 1'b1;
            progData.addr = 16'(i);
            progData.data = rows[i].instr;
            @(posedge CLK);
            #1;
        end
        progValid = 1'b0;
        repeat (4) @(posedge CLK);              // Idle with run low
        #1;
        run = 1'b1;
        wait (checkDone === 1'b1);
        if (errCount == 0 && rowCount == NUM_ROWS) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("Timeout: the retire port did not deliver all %0d records within %0d cycles",
                 NUM_ROWS, TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/retireChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module retireChecker #(
    parameter int NUM_ROWS = 20
) (
    input  wire                      CLK,
    input  wire                      RST,
    input  wire                      run,
    input  wire                      progReady,
    input  wire                      retireValid,
    input  wire                      retireReady,
    input  wire cpuBusPkg::retire_t  retireData,
    output logic                     done,
    output int                       errCount
);

    import cpuBusPkg::*;

    retire_t expRows   [NUM_ROWS];
    int      expGroup  [NUM_ROWS];
    int      groupRows [1:4];
    int      groupPass [1:4];
    int      accepted;                          // Records taken so far
    logic    runSeen;

    // Filled row by row from the testbench top
    task automatic loadExpected(input int idx, input logic [31:0] word, input logic [4:0] rdIdx,
                                input logic [31:0] value, input logic wrEn, input logic bad,
                                input int group);
        expRows[idx]  = '{pc: 32'(idx * 4), instr: word, rd: rdIdx, result: value,
                          writeEn: wrEn, illegal: bad, seq: 8'(idx)};
        expGroup[idx] = group;
    endtask

    function automatic string groupName(input int g);
        case (g)
            1:       return "ADDI setup";
            2:       return "ALU operations";
            3:       return "x0 handling";
            default: return "illegal words";
        endcase
    endfunction

    task automatic showRecord(input string label, input retire_t rec);
        $display("    %s pc=%h instr=%h rd=%0d result=%h writeEn=%b illegal=%b seq=%0d",
                 label, rec.pc, rec.instr, rec.rd, rec.result, rec.writeEn, rec.illegal, rec.seq);
    endtask

    task automatic checkRecord();
        retire_t expRec;
        int      g;
        expRec = expRows[accepted];
        g      = expGroup[accepted];
        groupRows[g]++;
        if (retireData !== expRec) begin        // pc and seq also catch lost or repeated records
            errCount++;
            $display("ERROR at %0t: row %0d retired a wrong record", $time, accepted);
            showRecord("got     ", retireData);
            showRecord("expected", expRec);
        end else begin
            groupPass[g]++;
        end
        $display("Row %0d (%s): %s", accepted, groupName(g),
                 (retireData === expRec) ? "pass" : "FAIL");
        accepted++;
    endtask

    always @(posedge CLK) begin
        if (RST) begin
            done     = 1'b0;
            errCount = 0;
            accepted = 0;
            runSeen  = 1'b0;
            for (int g = 1; g <= 4; g++) begin
                groupRows[g] = 0;
                groupPass[g] = 0;
            end
        end else begin
            if (retireValid && !runSeen) begin  // Load phase must stay quiet
                errCount++;
                $display("ERROR at %0t: retireValid high before run was raised", $time);
            end
            runSeen = runSeen || run;
            if (retireValid && retireReady && !done) begin
                checkRecord();
                if (accepted == NUM_ROWS) begin
                    for (int g = 1; g <= 4; g++) begin
                        $display("Group %0d (%s): %0d of %0d rows matched",
                                 g, groupName(g), groupPass[g], groupRows[g]);
                    end
                    $display("Checked %0d records, %0d errors", accepted, errCount);
                    done = 1'b1;
                end
            end
        end
        // Load port open only while halted, closed during reset
        if (progReady !== (RST ? 1'b0 : !run)) begin
            errCount++;
            $display("ERROR at %0t: progReady=%b with run=%b RST=%b",
                     $time, progReady, run, RST);
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
source/rvIsaPkg.sv
source/cpuBusPkg.sv
source/instrMem.sv
source/regFile.sv
source/instrDecoder.sv
source/alu.sv
source/cpuCore.sv
source/cpuTop.sv
dv/retireChecker.sv
dv/cpuTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Builds the core testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module cpuTb -f flist.f -o cpuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/cpuSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if echo "$simOut" | grep -qF 'All tests passed!'; then
    echo "Simulation PASSED"
    exit 0
fi
echo "Simulation FAILED"
exit 1

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire rvIsaPkg::aluOp_e  op,
    input  wire [31:0]             a,
    input  wire [31:0]             b,
    output logic [31:0]            y
);

    import rvIsaPkg::*;

    logic [4:0] shamt;
    logic       ltSigned;
    logic       ltUnsigned;

    assign shamt      = b[4:0];                 // RV32 uses five shift bits
    assign ltSigned   = $signed(a) < $signed(b);
    assign ltUnsigned = a < b;

    always_comb begin
        case (op)
            ADD:     y = a + b;
            SUB:     y = a - b;                 // Wraps modulo 2^32
            SLL:     y = a << shamt;
            SLT:     y = {31'd0, ltSigned};
            SLTU:    y = {31'd0, ltUnsigned};
            XOR:     y = a ^ b;
            SRL:     y = a >> shamt;
            SRA:     y = 32'($signed(a) >>> shamt);  // Sign fill
            OR:      y = a | b;
            AND:     y = a & b;
            default: y = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/cpuBusPkg.sv ====
`default_nettype none

package cpuBusPkg;

    // One program word on the load port
    typedef struct packed {
        logic [15:0] addr;                      // Word address
        logic [31:0] data;
    } progWrite_t;

    // Record of one executed instruction
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic [4:0]  rd;
        logic [31:0] result;                    // Zero for illegal words
        logic        writeEn;
        logic        illegal;
        logic [7:0]  seq;                       // Retire count mod 256
    } retire_t;

endpackage

`default_nettype wire

// ==== source/cpuCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCore #(
    parameter int IMEM_DEPTH = 64
) (
    input  wire                            CLK,
    input  wire                            RST,
    input  wire                            run,
    output logic [$clog2(IMEM_DEPTH)-1:0]  fetchAddr,
    input  wire  [31:0]                    instr,
    output logic                           retireValid,
    input  wire                            retireReady,
    output cpuBusPkg::retire_t             retireData
);

    import rvIsaPkg::*;

    localparam int ADDR_W = $clog2(IMEM_DEPTH);

    logic [31:0] pc;
    logic [7:0]  seqCnt;
    instr_u      curInstr;
    decoded_t    dec;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] opB;
    logic [31:0] aluY;
    logic        retireFree;
    logic        execute;

    assign curInstr  = instr;
    assign fetchAddr = pc[ADDR_W+1:2];          // Byte PC to word index

    instrDecoder uDecoder (
        .instr (curInstr),
        .dec   (dec)
    );

    regFile uRegFile (
        .CLK    (CLK),
        .RST    (RST),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .rd1    (rs1Data),
        .rd2    (rs2Data),
        .wrEn   (execute && dec.writeEn),
        .wrIdx  (dec.rd),
        .wrData (aluY)
    );

    assign opB = dec.useImm ? dec.imm : rs2Data;

    alu uAlu (
        .op (dec.aluOp),
        .a  (rs1Data),
        .b  (opB),
        .y  (aluY)
    );

    // The retire register can take a new record this cycle
    assign retireFree = !retireValid || retireReady;
    assign execute    = run && retireFree;

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc          <= 32'd0;
            seqCnt      <= 8'd0;
            retireValid <= 1'b0;
        end else if (execute) begin
            pc          <= pc + 32'd4;
            seqCnt      <= seqCnt + 8'd1;
            retireValid <= 1'b1;
        end else if (retireReady) begin
            retireValid <= 1'b0;                // Drained, nothing new
        end
    end

    always_ff @(posedge CLK) begin
        if (execute) begin
            retireData.pc      <= pc;
            retireData.instr   <= instr;
            retireData.rd      <= dec.rd;
            retireData.result  <= dec.legal ? aluY : 32'd0;
            retireData.writeEn <= dec.writeEn;
            retireData.illegal <= !dec.legal;
            retireData.seq     <= seqCnt;
        end
    end

    // Stalled record must hold until the consumer takes it
    retireHold: assert property (
        @(posedge CLK) disable iff (RST)
        (retireValid && !retireReady) |=> (retireValid && $stable(retireData))
    ) else $error("cpuCore retire record changed while stalled");

endmodule

`default_nettype wire

// ==== source/cpuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTop #(
    parameter int IMEM_DEPTH = 64
) (
    input  wire                          CLK,
    input  wire                          RST,
    input  wire                          run,
    input  wire                          progValid,
    output logic                         progReady,
    input  wire cpuBusPkg::progWrite_t   progData,
    output logic                         retireValid,
    input  wire                          retireReady,
    output cpuBusPkg::retire_t           retireData
);

    localparam int ADDR_W = $clog2(IMEM_DEPTH);

    logic [ADDR_W-1:0] fetchAddr;
    logic [31:0]       instrWord;
    logic              progWrEn;

    assign progReady = !run && !RST;            // Loading only while halted
    assign progWrEn  = progValid && progReady;

    instrMem #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) uInstrMem (
        .CLK       (CLK),
        .RST       (RST),
        .wrEn      (progWrEn),
        .wrData    (progData),
        .fetchAddr (fetchAddr),
        .instr     (instrWord)
    );

    cpuCore #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) uCore (
        .CLK         (CLK),
        .RST         (RST),
        .run         (run),
        .fetchAddr   (fetchAddr),
        .instr       (instrWord),
        .retireValid (retireValid),
        .retireReady (retireReady),
        .retireData  (retireData)
    );

endmodule

`default_nettype wire

// ==== source/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input  wire rvIsaPkg::instr_u    instr,
    output rvIsaPkg::decoded_t       dec
);

    import rvIsaPkg::*;

    always_comb begin
        dec        = '0;
        dec.aluOp  = ADD;
        dec.rs1    = instr.r.rs1;
        dec.rs2    = instr.r.rs2;
        dec.rd     = instr.r.rd;
        dec.imm    = {{20{instr.i.imm12[11]}}, instr.i.imm12};
        dec.useImm = 1'b0;
        dec.legal  = 1'b0;

        case (instr.r.opcode)
            OP: begin
                dec.legal = 1'b1;
                case (instr.r.funct3)
                    F3_ADD_SUB: dec.aluOp = instr.r.funct7[5] ? SUB : ADD;  // Bit 30
                    F3_SLL:     dec.aluOp = SLL;
                    F3_SLT:     dec.aluOp = SLT;
                    F3_SLTU:    dec.aluOp = SLTU;
                    F3_XOR:     dec.aluOp = XOR;
                    F3_SR:      dec.aluOp = instr.r.funct7[5] ? SRA : SRL;
                    F3_OR:      dec.aluOp = OR;
                    default:    dec.aluOp = AND;
                endcase
                if ((instr.r.funct7 != F7_BASE) && (instr.r.funct7 != F7_ALT)) begin
                    dec.legal = 1'b0;
                end
                // Only SUB and SRA use the alternate funct7
                if ((instr.r.funct7 == F7_ALT) &&
                    (instr.r.funct3 != F3_ADD_SUB) && (instr.r.funct3 != F3_SR)) begin
                    dec.legal = 1'b0;
                end
            end
            OP_IMM: begin
                dec.legal  = 1'b1;
                dec.useImm = 1'b1;
                dec.rs1    = instr.i.rs1;
                dec.rs2    = 5'd0;                  // No second register read
                dec.rd     = instr.i.rd;
                case (instr.i.funct3)
                    F3_ADD_SUB: dec.aluOp = ADD;    // No SUBI in the ISA
                    F3_SLL:     dec.aluOp = SLL;
                    F3_SLT:     dec.aluOp = SLT;
                    F3_SLTU:    dec.aluOp = SLTU;
                    F3_XOR:     dec.aluOp = XOR;
                    F3_SR:      dec.aluOp = instr.i.imm12[10] ? SRA : SRL;
                    F3_OR:      dec.aluOp = OR;
                    default:    dec.aluOp = AND;
                endcase
                // Shift immediates carry a funct7 in imm12[11:5]
                if ((instr.i.funct3 == F3_SLL) && (instr.i.imm12[11:5] != F7_BASE)) begin
                    dec.legal = 1'b0;
                end
                if ((instr.i.funct3 == F3_SR) && (instr.i.imm12[11:5] != F7_BASE) &&
                    (instr.i.imm12[11:5] != F7_ALT)) begin
                    dec.legal = 1'b0;
                end
            end
            default: dec.legal = 1'b0;          // Unsupported opcode
        endcase

        dec.writeEn = dec.legal;                // Legal implies a known opcode
    end

endmodule

`default_nettype wire

// ==== source/instrMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrMem #(
    parameter int IMEM_DEPTH = 64
) (
    input  wire                            CLK,
    input  wire                            RST,
    input  wire                            wrEn,
    input  wire cpuBusPkg::progWrite_t     wrData,
    input  wire [$clog2(IMEM_DEPTH)-1:0]   fetchAddr,
    output logic [31:0]                    instr
);

    localparam int ADDR_W = $clog2(IMEM_DEPTH);

    logic [31:0]       mem [IMEM_DEPTH];
    logic [ADDR_W-1:0] wrIdx;

    assign wrIdx = wrData.addr[ADDR_W-1:0];     // Drop unused upper address bits

    always_ff @(posedge CLK) begin
        if (wrEn) begin
            mem[wrIdx] <= wrData.data;
        end
    end

    assign instr = mem[fetchAddr];              // Combinational fetch

    // A loader that writes past the end would silently alias low words
    wrAddrInRange: assert property (
        @(posedge CLK) disable iff (RST)
        wrEn |-> (32'(wrData.addr) < IMEM_DEPTH)
    ) else $error("instrMem write address %0d beyond depth %0d", wrData.addr, IMEM_DEPTH);

endmodule

`default_nettype wire

// ==== source/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire          CLK,
    input  wire          RST,
    input  wire  [4:0]   rs1,
    input  wire  [4:0]   rs2,
    output logic [31:0]  rd1,
    output logic [31:0]  rd2,
    input  wire          wrEn,
    input  wire  [4:0]   wrIdx,
    input  wire  [31:0]  wrData
);

    logic [31:0] regs [32];                     // x0 slot is cleared and never written

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrIdx != 5'd0)) begin
            regs[wrIdx] <= wrData;              // Writes to x0 are dropped
        end
    end

    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    // x0 reads as zero on both ports, also right after a write aimed at it
    zeroRegReadsZero: assert property (
        @(posedge CLK) disable iff (RST)
        ((rs1 == 5'd0) |-> (rd1 == 32'd0)) and ((rs2 == 5'd0) |-> (rd2 == 32'd0))
    ) else $error("regFile x0 read back nonzero");

endmodule

`default_nettype wire

// ==== source/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,                    // Register-register ALU
        OP_IMM = 7'b0010011                     // Register-immediate ALU
    } opcode_e;

    // funct3 codes shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // SRL or SRA, picked by bit 30
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 values, also used for the upper bits of shift immediates
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // SUB and SRA

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeFields_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeFields_t;

    // One instruction word, seen in either format
    typedef union packed {
        logic [31:0]  raw;
        rTypeFields_t r;
        iTypeFields_t i;
    } instr_u;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } aluOp_e;

    typedef struct packed {
        aluOp_e      aluOp;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;                       // Already sign-extended
        logic        useImm;                    // Operand B from imm
        logic        legal;
        logic        writeEn;
    } decoded_t;

endpackage

`default_nettype wire
